/* source/radio_pkg.sv */
package radio_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths

   typedef logic [7:0]  set_addr_t;   // Settings register address
   typedef logic [31:0] word_t;       // Control and readback word
   typedef logic [63:0] vita_time_t;
   typedef logic [11:0] sample_t;     // One converter sample
   typedef logic [3:0]  rb_sel_t;     // Readback word number

   // Host request as presented on the four-phase port
   typedef struct packed {
      logic      we;
      set_addr_t addr;
      word_t     data;
   } host_cmd_t;

   // One beat on the settings bus
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      word_t     data;
   } set_bus_t;

   typedef struct packed {
      sample_t a;
      sample_t b;
   } iq_pair_t;

   ////////////////////////////////////////////////////////////////////
   // Settings register map

   localparam set_addr_t SR_MISC    = 8'd0;    // LED sw +3, PHY reset +4, LED src +6
   localparam set_addr_t SR_TESTSIG = 8'd8;    // One word per DAC pair
   localparam set_addr_t SR_TIME64  = 8'd10;   // High word staged, low word loads
   localparam set_addr_t SR_DIVSW   = 8'd180;  // Two switches

   // Word numbers not listed here read as zero
   localparam rb_sel_t RB_ADC0    = 4'd6;
   localparam rb_sel_t RB_ADC1    = 4'd7;
   localparam rb_sel_t RB_TIME_HI = 4'd10;
   localparam rb_sel_t RB_TIME_LO = 4'd11;
   localparam rb_sel_t RB_COMPAT  = 4'd12;
   localparam rb_sel_t RB_PPS_HI  = 4'd14;
   localparam rb_sel_t RB_PPS_LO  = 4'd15;

   localparam logic [7:0] LED_SRC_RESET  = 8'b0001_1110;  // HW owns the run LEDs
   localparam word_t      COMPAT_DEFAULT = {16'd8, 16'd2}; // Major, minor

   // Host port FSM
   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      ACK
   } port_state_t;

endpackage

/* source/host_port.sv */
`timescale 1ns/1ps

module host_port (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  logic                 req_i,
   input  radio_pkg::host_cmd_t cmd_i,
   input  radio_pkg::word_t     rb_word_i,
   output logic                 ack_o,
   output radio_pkg::word_t     rdata_o,
   output radio_pkg::set_bus_t  set_bus_o,
   output radio_pkg::rb_sel_t   rb_sel_o
);
   import radio_pkg::*;

   port_state_t state;

   ////////////////////////////////////////////////////////////////////
   // Handshake FSM
   // Each req gives one settings beat or one readback fetch and an ack two cycles later

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state         <= IDLE;
         ack_o         <= 1'b0;
         rdata_o       <= '0;
         set_bus_o.stb <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (req_i) begin
                  set_bus_o.stb <= cmd_i.we;  // Single beat for writes
                  state         <= ISSUE;
               end
            end
            ISSUE: begin
               set_bus_o.stb <= 1'b0;
               state         <= ACK;       // Readback mux registers now
            end
            ACK: begin
               if (!ack_o) begin
                  ack_o <= 1'b1;
                  if (!cmd_i.we)
                     rdata_o <= rb_word_i;
               end else if (!req_i) begin
                  ack_o <= 1'b0;          // Host has released req
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Command payload, captured as the request is taken
   always_ff @(posedge dsp_clk) begin
      if (state == IDLE && req_i) begin
         set_bus_o.addr <= cmd_i.addr;
         set_bus_o.data <= cmd_i.data;
         rb_sel_o       <= cmd_i.addr[3:0];
      end
   end

endmodule

/* source/setting_bank.sv */
`timescale 1ns/1ps

module setting_bank #(
   parameter logic [7:0] LED_SRC_AT_RESET = radio_pkg::LED_SRC_RESET
) (
   input  logic                dsp_clk,
   input  logic                por_rst,
   input  radio_pkg::set_bus_t set_bus_i,
   input  logic [1:0]          run_rx_i,
   input  logic [1:0]          run_tx_i,
   output logic [7:0]          leds_o,
   output logic                phy_resetn_o,
   output logic [1:0]          divsw_o,
   output radio_pkg::iq_pair_t dac0_o,
   output radio_pkg::iq_pair_t dac1_o
);
   import radio_pkg::*;

   logic [7:0] led_sw;
   logic [7:0] led_src;   // 1 = hardware, 0 = software
   logic [7:0] led_hw;
   logic       phy_rst;
   logic [1:0] divsw;
   word_t      testsig0;
   word_t      testsig1;

   ////////////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw   <= '0;
         led_src  <= LED_SRC_AT_RESET;
         phy_rst  <= 1'b0;
         divsw    <= 2'b11;          // Both switches on at power up
         testsig0 <= '0;
         testsig1 <= '0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            SR_MISC + 8'd3:    led_sw   <= set_bus_i.data[7:0];
            SR_MISC + 8'd4:    phy_rst  <= set_bus_i.data[0];
            SR_MISC + 8'd6:    led_src  <= set_bus_i.data[7:0];
            SR_TESTSIG + 8'd0: testsig0 <= set_bus_i.data;
            SR_TESTSIG + 8'd1: testsig1 <= set_bus_i.data;
            SR_DIVSW + 8'd0:   divsw[0] <= set_bus_i.data[0];
            SR_DIVSW + 8'd1:   divsw[1] <= set_bus_i.data[0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Outputs

   // Run activity per channel
   assign led_hw = {3'b000, run_tx_i[0], run_rx_i[0], run_tx_i[1], run_rx_i[1], 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   assign phy_resetn_o = ~phy_rst;
   assign divsw_o      = divsw;

   // Top 12 bits of each half drive the converters
   assign dac0_o = {testsig0[31:20], testsig0[15:4]};
   assign dac1_o = {testsig1[31:20], testsig1[15:4]};

endmodule

/* source/vita_timer.sv */
`timescale 1ns/1ps

module vita_timer (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  radio_pkg::set_bus_t   set_bus_i,
   input  logic                  pps_i,
   output radio_pkg::vita_time_t vita_time_o,
   output radio_pkg::vita_time_t vita_time_pps_o
);
   import radio_pkg::*;

   word_t      time_hi;     // Staged until the low word arrives
   word_t      time_lo;
   logic       load_pend;
   logic [1:0] pps_sync;
   logic       pps_d;
   logic       pps_rise;

   ////////////////////////////////////////////////////////////////////
   // Load path

   always_ff @(posedge dsp_clk) begin
      if (set_bus_i.stb && set_bus_i.addr == SR_TIME64 + 8'd0)
         time_hi <= set_bus_i.data;
      if (set_bus_i.stb && set_bus_i.addr == SR_TIME64 + 8'd1)
         time_lo <= set_bus_i.data;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         load_pend <= 1'b0;
      else
         load_pend <= set_bus_i.stb && set_bus_i.addr == SR_TIME64 + 8'd1;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         vita_time_o <= '0;
      else if (load_pend)
         vita_time_o <= {time_hi, time_lo};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   ////////////////////////////////////////////////////////////////////
   // PPS capture

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync <= 2'b00;
         pps_d    <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};  // Async input
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_rise = pps_sync[1] & ~pps_d;

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         vita_time_pps_o <= '0;
      else if (pps_rise)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

/* source/readback_mux.sv */
`timescale 1ns/1ps

module readback_mux #(
   parameter radio_pkg::word_t COMPAT_NUM = radio_pkg::COMPAT_DEFAULT
) (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  radio_pkg::rb_sel_t    rb_sel_i,
   input  radio_pkg::iq_pair_t   adc0_i,
   input  radio_pkg::iq_pair_t   adc1_i,
   input  radio_pkg::vita_time_t vita_time_i,
   input  radio_pkg::vita_time_t vita_time_pps_i,
   output radio_pkg::word_t      rb_word_o
);
   import radio_pkg::*;

   // Samples are left justified in each half word
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_word_o <= '0;
      end else begin
         case (rb_sel_i)
            RB_ADC0:    rb_word_o <= {adc0_i.a, 4'b0000, adc0_i.b, 4'b0000};
            RB_ADC1:    rb_word_o <= {adc1_i.a, 4'b0000, adc1_i.b, 4'b0000};
            RB_TIME_HI: rb_word_o <= vita_time_i[63:32];
            RB_TIME_LO: rb_word_o <= vita_time_i[31:0];
            RB_COMPAT:  rb_word_o <= COMPAT_NUM;
            RB_PPS_HI:  rb_word_o <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_word_o <= vita_time_pps_i[31:0];
            default:    rb_word_o <= '0;      // Unused word numbers
         endcase
      end
   end

endmodule

/* source/radio_core.sv */
`timescale 1ns/1ps

module radio_core #(
   parameter radio_pkg::word_t COMPAT_NUM = radio_pkg::COMPAT_DEFAULT
) (
   input  logic                 dsp_clk,
   input  logic                 por_rst,
   input  logic                 host_req_i,
   input  radio_pkg::host_cmd_t host_cmd_i,
   output logic                 host_ack_o,
   output radio_pkg::word_t     host_rdata_o,
   input  radio_pkg::iq_pair_t  adc0_i,
   input  radio_pkg::iq_pair_t  adc1_i,
   input  logic                 pps_i,
   input  logic [1:0]           run_rx_i,
   input  logic [1:0]           run_tx_i,
   output logic [7:0]           leds_o,
   output logic                 phy_resetn_o,
   output logic [1:0]           divsw_o,
   output radio_pkg::iq_pair_t  dac0_o,
   output radio_pkg::iq_pair_t  dac1_o
);
   import radio_pkg::*;

   set_bus_t   set_bus;
   rb_sel_t    rb_sel;
   word_t      rb_word;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////////////////////////////////////////////////////
   // Host side

   host_port host_port_i (
      .dsp_clk   (dsp_clk),
      .por_rst   (por_rst),
      .req_i     (host_req_i),
      .cmd_i     (host_cmd_i),
      .rb_word_i (rb_word),
      .ack_o     (host_ack_o),
      .rdata_o   (host_rdata_o),
      .set_bus_o (set_bus),
      .rb_sel_o  (rb_sel)
   );

   readback_mux #(.COMPAT_NUM(COMPAT_NUM)) readback_mux_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_sel_i        (rb_sel),
      .adc0_i          (adc0_i),
      .adc1_i          (adc1_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .rb_word_o       (rb_word)
   );

   ////////////////////////////////////////////////////////////////////
   // Settings consumers

   setting_bank setting_bank_i (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .set_bus_i    (set_bus),
      .run_rx_i     (run_rx_i),
      .run_tx_i     (run_tx_i),
      .leds_o       (leds_o),
      .phy_resetn_o (phy_resetn_o),
      .divsw_o      (divsw_o),
      .dac0_o       (dac0_o),
      .dac1_o       (dac1_o)
   );

   vita_timer vita_timer_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_bus_i       (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
   parameter realtime PERIOD_NS = 4.0
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // 250 MHz by default

endmodule

/* tb/host_port_asserts.sv */
`timescale 1ns/1ps

module host_port_asserts (
   input logic                dsp_clk,
   input logic                por_rst,
   input logic                req_i,
   input logic                ack_i,
   input radio_pkg::set_bus_t set_bus_i
);

   // Ack only answers a request that is still held
   ack_needs_req: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $rose(ack_i) |-> $past(req_i))
      else $error("host_port raised ack without a pending request");

   stb_one_cycle: assert property (@(posedge dsp_clk) disable iff (por_rst)
      set_bus_i.stb |=> !set_bus_i.stb)
      else $error("settings strobe stayed high for more than one cycle");

   ack_waits_release: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $fell(ack_i) |-> !$past(req_i))
      else $error("host_port dropped ack while req was still high");

   // Req first seen three samples before ack shows high
   ack_latency: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $rose(ack_i) |-> $past(req_i, 3) && !$past(req_i, 4))
      else $error("ack did not rise two cycles after the request was seen");

endmodule

/* tb/radio_core_tb.sv */
`timescale 1ns/1ps

module radio_core_tb;
   import radio_pkg::*;

   // One row: host command, held inputs, expected results
   typedef struct packed {
      logic       we;
      set_addr_t  addr;
      word_t      data;
      iq_pair_t   adc0;
      iq_pair_t   adc1;
      logic [3:0] run;         // {tx, rx}
      word_t      exp_word;
      logic [7:0] exp_leds;
      logic [2:0] exp_bits;    // {divsw, phy_resetn}
      iq_pair_t   exp_dac0;
      iq_pair_t   exp_dac1;
   } entry_t;

   // Word numbers with nothing behind them
   localparam logic [35:0] UNUSED_SEL = {4'd13, 4'd9, 4'd8, 4'd5, 4'd4, 4'd3, 4'd2, 4'd1, 4'd0};

   logic       dsp_clk;
   logic       por_rst;
   logic       host_req_i;
   host_cmd_t  host_cmd_i;
   logic       host_ack_o;
   word_t      host_rdata_o;
   iq_pair_t   adc0_i;
   iq_pair_t   adc1_i;
   iq_pair_t   dac0_o;
   iq_pair_t   dac1_o;
   logic       pps_i;
   logic [1:0] run_rx_i;
   logic [1:0] run_tx_i;
   logic [1:0] divsw_o;
   logic [7:0] leds_o;
   logic       phy_resetn_o;

   entry_t     table_q[$];
   int         seed = 39422;
   int         cycle_count = 0;
   int         timeout_limit = 200;

   // Expected register contents while the table is built
   logic [7:0] m_led_sw = 8'h00;
   logic [7:0] m_led_src = 8'b0001_1110;
   logic       m_phy = 1'b0;
   logic [1:0] m_divsw = 2'b11;
   word_t      m_ts0 = '0;
   word_t      m_ts1 = '0;
   logic [3:0] cur_run;
   iq_pair_t   cur_adc0;
   iq_pair_t   cur_adc1;
   word_t      time_hi;
   word_t      time_lo;

   tb_clkgen clkgen_i (.clk_o(dsp_clk));

   radio_core dut_i (.*);

   bind host_port host_port_asserts host_port_asserts_i (.dsp_clk(dsp_clk), .por_rst(por_rst),
      .req_i(req_i), .ack_i(ack_o), .set_bus_i(set_bus_o));

   ///////////////////////////////////////////////////////////////////////
   // Reference rules

   function automatic word_t rand_word();
      return word_t'($random(seed));
   endfunction

   // Hardware bit where the source bit is set, software bit elsewhere
   function automatic logic [7:0] leds_expected(input logic [3:0] run);
      logic [7:0] hw;
      logic [7:0] leds;
      hw    = '0;
      hw[4] = run[2];   // tx0
      hw[3] = run[0];   // rx0
      hw[2] = run[3];   // tx1
      hw[1] = run[1];   // rx1
      for (int b = 0; b < 8; b++)
         leds[b] = m_led_src[b] ? hw[b] : m_led_sw[b];
      return leds;
   endfunction

   function automatic iq_pair_t dac_expected(input word_t w);
      return {w[31:20], w[15:4]};
   endfunction

   function automatic word_t adc_word(input iq_pair_t p);
      return {p.a, 4'h0, p.b, 4'h0};
   endfunction

   task automatic new_inputs();
      word_t r;
      r        = rand_word();
      cur_run  = r[3:0];
      cur_adc0 = r[31:8];
      r        = rand_word();
      cur_adc1 = r[23:0];
   endtask

   task automatic add_entry(input logic we, input set_addr_t addr, input word_t data,
                            input word_t exp_word);
      entry_t e;
      if (we) begin
         case (addr)
            SR_MISC + 8'd3:    m_led_sw   = data[7:0];
            SR_MISC + 8'd4:    m_phy      = data[0];
            SR_MISC + 8'd6:    m_led_src  = data[7:0];
            SR_TESTSIG:        m_ts0      = data;
            SR_TESTSIG + 8'd1: m_ts1      = data;
            SR_DIVSW:          m_divsw[0] = data[0];
            SR_DIVSW + 8'd1:   m_divsw[1] = data[0];
            default: ;
         endcase
      end
      e.we       = we;
      e.addr     = addr;
      e.data     = data;
      e.adc0     = cur_adc0;
      e.adc1     = cur_adc1;
      e.run      = cur_run;
      e.exp_word = exp_word;
      e.exp_leds = leds_expected(cur_run);
      e.exp_bits = {m_divsw, ~m_phy};
      e.exp_dac0 = dac_expected(m_ts0);
      e.exp_dac1 = dac_expected(m_ts1);
      table_q.push_back(e);
   endtask

   task automatic build_table();
      word_t w;
      new_inputs();
      add_entry(1'b0, {4'h0, RB_COMPAT}, '0, {16'd8, 16'd2});   // Major 8, minor 2
      repeat (2) begin
         new_inputs();
         add_entry(1'b1, SR_TESTSIG, rand_word(), '0);
         add_entry(1'b1, SR_TESTSIG + 8'd1, rand_word(), '0);
      end
      for (int i = 0; i < 9; i++) begin
         new_inputs();
         if (i < 3) begin
            add_entry(1'b1, SR_MISC + 8'd3, rand_word(), '0);
            add_entry(1'b1, SR_MISC + 8'd6, rand_word(), '0);
         end
         add_entry(1'b0, {4'h0, UNUSED_SEL[i*4 +: 4]}, '0, '0);
      end
      add_entry(1'b1, SR_MISC + 8'd4, 32'd1, '0);   // PHY held in reset
      add_entry(1'b1, SR_MISC + 8'd4, 32'd0, '0);
      add_entry(1'b1, SR_DIVSW, 32'd0, '0);
      add_entry(1'b1, SR_DIVSW + 8'd1, 32'd0, '0);
      add_entry(1'b1, SR_DIVSW, 32'd1, '0);
      repeat (3) begin
         new_inputs();
         add_entry(1'b0, {4'h0, RB_ADC0}, '0, adc_word(cur_adc0));
         add_entry(1'b0, {4'h0, RB_ADC1}, '0, adc_word(cur_adc1));
      end
      // Low word kept clear of a carry into the high word
      time_hi = rand_word();
      w       = rand_word();
      time_lo = {1'b0, w[30:0]};
      add_entry(1'b1, SR_TIME64, time_hi, '0);
      add_entry(1'b1, SR_TIME64 + 8'd1, time_lo, '0);
      add_entry(1'b0, {4'h0, RB_TIME_HI}, '0, time_hi);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Host handshake and compares

   task automatic host_xfer(input logic we, input set_addr_t addr, input word_t data,
                            output word_t rdata);
      host_cmd_t cmd;
      cmd.we   = we;
      cmd.addr = addr;
      cmd.data = data;
      @(posedge dsp_clk);
      host_cmd_i <= cmd;
      host_req_i <= 1'b1;
      do begin
         @(posedge dsp_clk);
      end while (!host_ack_o);
      rdata = host_rdata_o;     // Valid while ack is high
      host_req_i <= 1'b0;
      do begin
         @(posedge dsp_clk);
      end while (host_ack_o);
   endtask

   task automatic stop_on_failure();
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_range(input string what, input word_t got, input word_t lo,
                              input word_t hi);
      if (got < lo || got > hi) begin
         $display("[FAIL] %0t: %s is %h, expected %h to %h", $time, what, got, lo, hi);
         stop_on_failure();
      end
   endtask

   task automatic check_leds(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_pair(input string what, input iq_pair_t got, input iq_pair_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %h/%h, expected %h/%h", $time, what,
                  got.a, got.b, exp.a, exp.b);
         stop_on_failure();
      end
   endtask

   task automatic check_bits(input string what, input logic [2:0] got, input logic [2:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("Timeout: the test did not finish within %0d clock cycles", timeout_limit);
         stop_on_failure();
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin : main
      entry_t e;
      word_t  rdata;
      word_t  lo_first;
      word_t  lo_last;

      por_rst    <= 1'b1;
      host_req_i <= 1'b0;
      host_cmd_i <= '0;
      adc0_i     <= '0;
      adc1_i     <= '0;
      pps_i      <= 1'b0;
      run_rx_i   <= 2'b00;
      run_tx_i   <= 2'b00;
      build_table();
      timeout_limit = table_q.size() * 12 + 200;
      repeat (16) @(posedge dsp_clk);
      por_rst <= 1'b0;

      foreach (table_q[i]) begin
         e = table_q[i];
         @(posedge dsp_clk);
         adc0_i   <= e.adc0;
         adc1_i   <= e.adc1;
         run_rx_i <= e.run[1:0];
         run_tx_i <= e.run[3:2];
         host_xfer(e.we, e.addr, e.data, rdata);
         if (!e.we)
            check_word($sformatf("entry %0d read word", i), rdata, e.exp_word);
         check_leds($sformatf("entry %0d leds", i), leds_o, e.exp_leds);
         check_bits($sformatf("entry %0d divsw and phy_resetn", i),
                    {divsw_o, phy_resetn_o}, e.exp_bits);
         check_pair($sformatf("entry %0d dac0", i), dac0_o, e.exp_dac0);
         check_pair($sformatf("entry %0d dac1", i), dac1_o, e.exp_dac1);
      end

      // Time keeps counting from the loaded value
      host_xfer(1'b0, {4'h0, RB_TIME_LO}, '0, lo_first);
      check_range("time low after load", lo_first, time_lo + 32'd1, time_lo + 32'd99);

      @(posedge dsp_clk);
      pps_i <= 1'b1;
      repeat (4) @(posedge dsp_clk);
      pps_i <= 1'b0;
      repeat (4) @(posedge dsp_clk);   // Synchronizer and latch settle

      host_xfer(1'b0, {4'h0, RB_PPS_HI}, '0, rdata);
      check_word("PPS time high", rdata, time_hi);
      host_xfer(1'b0, {4'h0, RB_PPS_LO}, '0, rdata);
      host_xfer(1'b0, {4'h0, RB_TIME_LO}, '0, lo_last);
      check_range("PPS time low", rdata, time_lo + 32'd1, lo_last - 32'd1);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* verilog.f */
source/radio_pkg.sv
source/host_port.sv
source/setting_bank.sv
source/vita_timer.sv
source/readback_mux.sv
source/radio_core.sv
tb/tb_clkgen.sv
tb/host_port_asserts.sv
tb/radio_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the radio_core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module radio_core_tb -f verilog.f --Mdir obj_dir

./obj_dir/Vradio_core_tb
